//--- flist.f
+incdir+include
hdl/lsu_pkg.sv
hdl/mem_op_decoder.sv
hdl/access_guard.sv
hdl/data_mem.sv
hdl/lsu_top.sv
verif/tb_clock_gen.sv
verif/lsu_tb.sv

//--- Bender.yml
package:
  name: lsu

export_include_dirs:
  - include

sources:
  - hdl/lsu_pkg.sv
  - hdl/mem_op_decoder.sv
  - hdl/access_guard.sv
  - hdl/data_mem.sv
  - hdl/lsu_top.sv
  - target: simulation
    files:
      - verif/tb_clock_gen.sv
      - verif/lsu_tb.sv

//--- verif/lsu_tb.sv
`timescale 1ns/100ps
`default_nettype none

`include "lsu_settings.svh"

module lsu_tb import lsu_pkg::*; ();

    localparam int     CLK_PERIOD   = 40;
    localparam int     RESET_CYCLES = 4;
    localparam int     N_RAND       = 48;
    localparam int     MARGIN_NS    = 800;
    localparam instr_t NOP          = 32'h0000_0013;
    localparam logic [2:0] F3_B  = 3'b000;
    localparam logic [2:0] F3_H  = 3'b001;
    localparam logic [2:0] F3_W  = 3'b010;
    localparam logic [2:0] F3_BU = 3'b100;
    localparam logic [2:0] F3_HU = 3'b101;

    typedef struct packed {
        instr_t       instr;
        word_t        base;
        word_t        store_data;
        logic         cfg_we;
        addr_t        cfg_limit;
        word_t        exp_data;
        logic         exp_ld;
        logic         exp_fault;
        fault_count_t exp_count;
    } row_t;

    logic         clk;
    logic         reset;
    instr_t       instr;
    word_t        base;
    word_t        store_data;
    logic         cfg_we;
    addr_t        cfg_limit;
    word_t        load_data;
    logic         load_into_reg;
    logic         fault;
    fault_count_t fault_count;

    row_t         rows[$];
    word_t        model_mem [0:`LSU_MEM_WORDS-1];
    fault_count_t fault_total;
    logic [15:0]  lfsr_state;
    logic         table_built;

    tb_clock_gen #(.PERIOD_NS(CLK_PERIOD), .RESET_CYCLES(RESET_CYCLES)) clock_i (
        .clk   (clk),
        .reset (reset)
    );

    lsu_top lsu_top_i (
        .clk           (clk),
        .reset         (reset),
        .instr         (instr),
        .base          (base),
        .store_data    (store_data),
        .cfg_we        (cfg_we),
        .cfg_limit     (cfg_limit),
        .load_data     (load_data),
        .load_into_reg (load_into_reg),
        .fault         (fault),
        .fault_count   (fault_count)
    );

    // fibonacci lfsr, taps 16 14 13 11, one step per bit taken
    function automatic logic [31:0] lfsr_bits(input int n);
        logic [31:0] r;
        logic        fb;
        r = '0;
        for (int k = 0; k < n; k++) begin
            fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
            lfsr_state = {lfsr_state[14:0], fb};
            r = {r[30:0], fb};
        end
        return r;
    endfunction

    function automatic addr_t sext12(input logic [11:0] v);
        return {{20{v[11]}}, v};
    endfunction

    // rs1 = x1, rs2 = x2, rd = x5
    function automatic instr_t load_instr(input logic [2:0] f3, input logic [11:0] imm);
        return {imm, 5'd1, f3, 5'd5, 7'b0000011};
    endfunction

    function automatic instr_t store_instr(input logic [2:0] f3, input logic [11:0] imm);
        return {imm[11:5], 5'd2, 5'd1, f3, imm[4:0], 7'b0100011};
    endfunction

    // count seen at check time only includes faults of earlier rows
    task automatic append_row(input instr_t i, input word_t b, input word_t sd, input logic we,
                              input addr_t lim, input word_t ed, input logic el, input logic ef);
        rows.push_back('{i, b, sd, we, lim, ed, el, ef, fault_total});
        if (ef) begin
            fault_total = fault_total + 1'b1;
        end
    endtask

    task automatic load_row(input logic [2:0] f3, input addr_t a, input word_t ed, input logic ef);
        append_row(load_instr(f3, 12'h004), a - 32'd4, '0, 1'b0, '0, ef ? '0 : ed, !ef, ef);
    endtask

    task automatic store_row(input logic [2:0] f3, input addr_t a, input word_t sd, input logic ef);
        append_row(store_instr(f3, 12'hff8), a + 32'd8, sd, 1'b0, '0, '0, 1'b0, ef);
    endtask

    task automatic limit_row(input addr_t lim);
        append_row(NOP, '0, '0, 1'b1, lim, '0, 1'b0, 1'b0);
    endtask

    task automatic directed_rows;
        // word round trip
        store_row(F3_W, 32'h100, 32'h1234_5678, 1'b0);
        load_row(F3_W, 32'h100, 32'h1234_5678, 1'b0);
        // lane merging, upper bits of store data must be ignored
        store_row(F3_B, 32'h101, 32'hcccc_ccab, 1'b0);
        store_row(F3_H, 32'h102, 32'h5555_beef, 1'b0);
        store_row(F3_B, 32'h103, 32'h0000_0080, 1'b0);
        load_row(F3_W, 32'h100, 32'h80ef_ab78, 1'b0);
        store_row(F3_B, 32'h100, 32'hffff_ff11, 1'b0);
        store_row(F3_B, 32'h102, 32'h0000_0022, 1'b0);
        store_row(F3_H, 32'h100, 32'h9999_7f3c, 1'b0);
        load_row(F3_W, 32'h100, 32'h8022_7f3c, 1'b0);
        // sign and zero extension
        load_row(F3_B, 32'h103, 32'hffff_ff80, 1'b0);
        load_row(F3_BU, 32'h103, 32'h0000_0080, 1'b0);
        load_row(F3_H, 32'h102, 32'hffff_8022, 1'b0);
        load_row(F3_HU, 32'h102, 32'h0000_8022, 1'b0);
        load_row(F3_B, 32'h101, 32'h0000_007f, 1'b0);
        load_row(F3_H, 32'h100, 32'h0000_7f3c, 1'b0);
        // misaligned accesses
        load_row(F3_H, 32'h101, '0, 1'b1);
        load_row(F3_W, 32'h102, '0, 1'b1);
        store_row(F3_W, 32'h101, 32'hdead_beef, 1'b1);
        load_row(F3_HU, 32'h103, '0, 1'b1);
        load_row(F3_W, 32'h100, 32'h8022_7f3c, 1'b0);
        // write protection below 0x200
        store_row(F3_W, 32'h1f0, 32'h0bad_f00d, 1'b0);
        limit_row(32'h200);
        store_row(F3_W, 32'h1f0, 32'haaaa_5555, 1'b1);
        store_row(F3_B, 32'h1ff, 32'h0000_0042, 1'b1);
        store_row(F3_W, 32'h200, 32'h600d_cafe, 1'b0);
        load_row(F3_W, 32'h200, 32'h600d_cafe, 1'b0);
        load_row(F3_W, 32'h1f0, 32'h0bad_f00d, 1'b0);
        append_row(NOP, '0, '0, 1'b0, '0, '0, 1'b0, 1'b0);
    endtask

    // random words in the upper half of the array, untouched by the directed rows
    task automatic random_rows;
        logic [31:0] widx;
        logic [31:0] rnd;
        logic [11:0] imm;
        addr_t       a;
        word_t       data;
        for (int k = 0; k < N_RAND; k++) begin
            rnd = lfsr_bits(9);
            widx = 512 + rnd;
            a = widx << 2;
            data = lfsr_bits(32);
            rnd = lfsr_bits(12);
            imm = rnd[11:0];
            append_row(store_instr(F3_W, imm), a - sext12(imm), data, 1'b0, '0, '0, 1'b0, 1'b0);
            model_mem[widx] = data;
            // back-to-back load of the word just stored
            rnd = lfsr_bits(12);
            imm = rnd[11:0];
            append_row(load_instr(F3_W, imm), a - sext12(imm), '0, 1'b0, '0, data, 1'b1, 1'b0);
            rnd = lfsr_bits(9);
            widx = 512 + rnd;
            a = widx << 2;
            rnd = lfsr_bits(12);
            imm = rnd[11:0];
            append_row(load_instr(F3_W, imm), a - sext12(imm), '0, 1'b0, '0,
                       model_mem[widx], 1'b1, 1'b0);
        end
    endtask

    task automatic word_check(input string name, input int row, input word_t exp, input word_t act);
        if (act !== exp) begin
            $display("Error: %s row %0d expected 0x%h got 0x%h", name, row, exp, act);
            $display("TEST FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic flag_check(input string name, input int row, input logic exp, input logic act);
        if (act !== exp) begin
            $display("Error: %s row %0d expected 0x%h got 0x%h", name, row, exp, act);
            $display("TEST FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic count_check(input string name, input int row, input fault_count_t exp,
                               input fault_count_t act);
        if (act !== exp) begin
            $display("Error: %s row %0d expected 0x%h got 0x%h", name, row, exp, act);
            $display("TEST FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    initial begin
        instr       = NOP;
        base        = '0;
        store_data  = '0;
        cfg_we      = 1'b0;
        cfg_limit   = '0;
        table_built = 1'b0;
        fault_total = '0;
        lfsr_state  = 16'd34;
        for (int w = 0; w < `LSU_MEM_WORDS; w++) begin
            model_mem[w] = '0;
        end
        directed_rows();
        random_rows();
        table_built = 1'b1;

        @(negedge reset);
        @(negedge clk);
        flag_check("load_into_reg", -1, 1'b0, load_into_reg);
        flag_check("fault", -1, 1'b0, fault);
        count_check("fault_count", -1, '0, fault_count);

        for (int i = 0; i < rows.size(); i++) begin
            instr     = rows[i].instr;
            base      = rows[i].base;
            cfg_we    = rows[i].cfg_we;
            cfg_limit = rows[i].cfg_limit;
            @(negedge clk);
            word_check("load_data", i, rows[i].exp_data, load_data);
            flag_check("load_into_reg", i, rows[i].exp_ld, load_into_reg);
            flag_check("fault", i, rows[i].exp_fault, fault);
            count_check("fault_count", i, rows[i].exp_count, fault_count);
            // rs2 reaches the memory together with the registered op
            store_data = rows[i].store_data;
        end
        instr  = NOP;
        cfg_we = 1'b0;
        @(negedge clk);
        $display("TEST OK");
        $finish;
    end

    // watchdog sized from the table length
    initial begin
        wait (table_built === 1'b1);
        #((rows.size() + RESET_CYCLES) * 2 * CLK_PERIOD + MARGIN_NS);
        $display("the run did not finish in time, watchdog expired");
        $display("TEST FAILED");
        $fatal(1, "timeout");
    end

endmodule

`default_nettype wire

//--- verif/tb_clock_gen.sv
`timescale 1ns/100ps
`default_nettype none

module tb_clock_gen #(
    parameter int PERIOD_NS    = 40,
    parameter int RESET_CYCLES = 4
) (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    // reset held over the first rising edges, released on a falling edge
    initial begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        reset <= 1'b0;
    end

endmodule

`default_nettype wire

//--- hdl/lsu_top.sv
`timescale 1ns/100ps
`default_nettype none

module lsu_top import lsu_pkg::*; (
    input  logic         clk,
    input  logic         reset,
    input  instr_t       instr,
    input  word_t        base,
    input  word_t        store_data,
    input  logic         cfg_we,
    input  addr_t        cfg_limit,
    output word_t        load_data,
    output logic         load_into_reg,
    output logic         fault,
    output fault_count_t fault_count
);

    // registered operation, shared by guard and memory
    op_code_t op;
    addr_t    addr;
    logic     access_ok;

    mem_op_decoder mem_op_decoder_i (
        .clk   (clk),
        .reset (reset),
        .instr (instr),
        .base  (base),
        .op    (op),
        .addr  (addr)
    );

    access_guard access_guard_i (
        .clk         (clk),
        .reset       (reset),
        .cfg_we      (cfg_we),
        .cfg_limit   (cfg_limit),
        .op          (op),
        .addr        (addr),
        .access_ok   (access_ok),
        .fault       (fault),
        .fault_count (fault_count)
    );

    data_mem data_mem_i (
        .clk           (clk),
        .reset         (reset),
        .op            (op),
        .addr          (addr),
        .access_ok     (access_ok),
        .store_data    (store_data),
        .load_data     (load_data),
        .load_into_reg (load_into_reg)
    );

endmodule

`default_nettype wire

//--- hdl/data_mem.sv
`timescale 1ns/100ps
`default_nettype none

`include "lsu_settings.svh"

module data_mem import lsu_pkg::*; (
    input  logic     clk,
    input  logic     reset,
    input  op_code_t op,
    input  addr_t    addr,
    input  logic     access_ok,
    input  word_t    store_data,
    output word_t    load_data,
    output logic     load_into_reg
);

    localparam int IDX_W = $clog2(`LSU_MEM_WORDS);

    word_t            mem [0:`LSU_MEM_WORDS-1];
    logic [IDX_W-1:0] word_idx;
    logic [1:0]       byte_sel;
    logic             half_sel;
    word_t            raw_word;
    logic [7:0]       byte_lane;
    logic [15:0]      half_lane;
    word_t            lane_data;
    word_t            store_word;
    logic             is_load;
    logic             is_store;

    // word index wraps modulo the array depth
    assign word_idx = addr[IDX_W+1:2];
    assign byte_sel = addr[1:0];
    assign half_sel = addr[1];

    // asynchronous read
    assign raw_word  = mem[word_idx];
    assign byte_lane = raw_word[{byte_sel, 3'b000} +: 8];
    assign half_lane = raw_word[{half_sel, 4'b0000} +: 16];

    // load lane select and extension
    always_comb begin
        is_load   = 1'b0;
        lane_data = '0;
        case (op)
            `LSU_OP_LB: begin
                is_load   = 1'b1;
                lane_data = {{24{byte_lane[7]}}, byte_lane};
            end
            `LSU_OP_LH: begin
                is_load   = 1'b1;
                lane_data = {{16{half_lane[15]}}, half_lane};
            end
            `LSU_OP_LW: begin
                is_load   = 1'b1;
                lane_data = raw_word;
            end
            `LSU_OP_LBU: begin
                is_load   = 1'b1;
                lane_data = {24'b0, byte_lane};
            end
            `LSU_OP_LHU: begin
                is_load   = 1'b1;
                lane_data = {16'b0, half_lane};
            end
            default: begin
                is_load   = 1'b0;
            end
        endcase
    end

    // refused loads return zero
    assign load_into_reg = is_load & access_ok;
    assign load_data     = access_ok ? lane_data : '0;

    // merge store data into the addressed lane of the old word
    always_comb begin
        is_store   = 1'b0;
        store_word = raw_word;
        case (op)
            `LSU_OP_SB: begin
                is_store = 1'b1;
                store_word[{byte_sel, 3'b000} +: 8] = store_data[7:0];
            end
            `LSU_OP_SH: begin
                is_store = 1'b1;
                store_word[{half_sel, 4'b0000} +: 16] = store_data[15:0];
            end
            `LSU_OP_SW: begin
                is_store   = 1'b1;
                store_word = store_data;
            end
            default: begin
                is_store = 1'b0;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `LSU_MEM_WORDS; i++) begin
                mem[i] <= '0;
            end
        end else if (is_store && access_ok) begin
            mem[word_idx] <= store_word;
        end
    end

    // decoder must never hand over more than one operation at a time
    a_op_onehot: assert property (@(posedge clk) disable iff (reset) $onehot0(op));

endmodule

`default_nettype wire

//--- hdl/access_guard.sv
`timescale 1ns/100ps
`default_nettype none

`include "lsu_settings.svh"

module access_guard import lsu_pkg::*; (
    input  logic         clk,
    input  logic         reset,
    input  logic         cfg_we,
    input  addr_t        cfg_limit,
    input  op_code_t     op,
    input  addr_t        addr,
    output logic         access_ok,
    output logic         fault,
    output fault_count_t fault_count
);

    localparam op_code_t HALF_OPS  = `LSU_OP_LH | `LSU_OP_LHU | `LSU_OP_SH;
    localparam op_code_t WORD_OPS  = `LSU_OP_LW | `LSU_OP_SW;
    localparam op_code_t STORE_OPS = `LSU_OP_SB | `LSU_OP_SH | `LSU_OP_SW;

    addr_t limit;
    logic  is_half;
    logic  is_word;
    logic  is_store;
    logic  misaligned;
    logic  protected_store;

    // a zero limit protects nothing
    always_ff @(posedge clk) begin
        if (reset) begin
            limit <= '0;
        end else if (cfg_we) begin
            limit <= cfg_limit;
        end
    end

    assign is_half  = |(op & HALF_OPS);
    assign is_word  = |(op & WORD_OPS);
    assign is_store = |(op & STORE_OPS);

    assign misaligned      = (is_half & addr[0]) | (is_word & (|addr[1:0]));
    assign protected_store = is_store & (addr < limit);

    assign access_ok = ~(misaligned | protected_store);

    // only a real memory operation can fault
    assign fault = (op != `LSU_OP_NONE) & ~access_ok;

    always_ff @(posedge clk) begin
        if (reset) begin
            fault_count <= '0;
        end else if (fault) begin
            fault_count <= fault_count + 1'b1;
        end
    end

    a_no_fault_idle: assert property (
        @(posedge clk) disable iff (reset) (op == `LSU_OP_NONE) |-> !fault
    );

endmodule

`default_nettype wire

//--- hdl/mem_op_decoder.sv
`timescale 1ns/100ps
`default_nettype none

`include "lsu_settings.svh"

module mem_op_decoder import lsu_pkg::*; (
    input  logic     clk,
    input  logic     reset,
    input  instr_t   instr,
    input  word_t    base,
    output op_code_t op,
    output addr_t    addr
);

    localparam logic [6:0] OPCODE_LOAD  = 7'b0000011;
    localparam logic [6:0] OPCODE_STORE = 7'b0100011;

    logic [6:0] opcode;
    logic [2:0] funct3;
    word_t      imm_i;
    word_t      imm_s;
    op_code_t   op_next;
    addr_t      addr_next;

    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];

    // sign-extended I-type immediate for loads and S-type for stores
    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};

    always_comb begin
        op_next   = `LSU_OP_NONE;
        addr_next = base;
        case (opcode)
            OPCODE_LOAD: begin
                addr_next = base + imm_i;
                case (funct3)
                    3'b000:  op_next = `LSU_OP_LB;
                    3'b001:  op_next = `LSU_OP_LH;
                    3'b010:  op_next = `LSU_OP_LW;
                    3'b100:  op_next = `LSU_OP_LBU;
                    3'b101:  op_next = `LSU_OP_LHU;
                    default: op_next = `LSU_OP_NONE;
                endcase
            end
            OPCODE_STORE: begin
                addr_next = base + imm_s;
                case (funct3)
                    3'b000:  op_next = `LSU_OP_SB;
                    3'b001:  op_next = `LSU_OP_SH;
                    3'b010:  op_next = `LSU_OP_SW;
                    default: op_next = `LSU_OP_NONE;
                endcase
            end
            default: begin
                op_next = `LSU_OP_NONE;
            end
        endcase
    end

    // registered op code and effective address
    always_ff @(posedge clk) begin
        if (reset) begin
            op <= `LSU_OP_NONE;
        end else begin
            op <= op_next;
        end
    end

    always_ff @(posedge clk) begin
        addr <= addr_next;
    end

endmodule

`default_nettype wire

//--- hdl/lsu_pkg.sv
`default_nettype none

package lsu_pkg;

    // data word, used for load data, store data and rs1 values
    typedef logic [31:0] word_t;

    // byte address
    typedef logic [31:0] addr_t;

    // raw RV32I instruction word
    typedef logic [31:0] instr_t;

    // one-hot memory operation code, one bit per load/store kind
    typedef logic [63:0] op_code_t;

    // number of refused accesses, wraps
    typedef logic [7:0] fault_count_t;

endpackage

`default_nettype wire

//--- include/lsu_settings.svh
`ifndef LSU_SETTINGS_SVH
`define LSU_SETTINGS_SVH

// depth of the data array in 32-bit words
`define LSU_MEM_WORDS 1024

// one-hot memory operation codes, 64 bits wide
// loads
`define LSU_OP_LB   64'h0000_0000_0000_0001
`define LSU_OP_LH   64'h0000_0000_0000_0002
`define LSU_OP_LW   64'h0000_0000_0000_0004
`define LSU_OP_LBU  64'h0000_0000_0000_0008
`define LSU_OP_LHU  64'h0000_0000_0000_0010

// stores
`define LSU_OP_SB   64'h0000_0000_0000_0020
`define LSU_OP_SH   64'h0000_0000_0000_0040
`define LSU_OP_SW   64'h0000_0000_0000_0080

// no memory operation
`define LSU_OP_NONE 64'h0000_0000_0000_0000

`endif
